//--- dv/fetchChecker.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetchChecker (
    input  logic               clk,
    input  logic               rst,
    input  logic               interruptPending,
    input  logic               redirValid,
    input  fetchPkg::fetchId_t redirFetchId,
    input  fetchPkg::pc_t      redirTarget,
    input  logic               redirWfi,
    input  logic               btUpdValid,
    input  fetchPkg::pc_t      btUpdSrc,
    input  fetchPkg::pc_t      btUpdDst,
    input  logic               ready,
    input  fetchPkg::fetchId_t pcReadAddr0,
    input  fetchPkg::fetchId_t pcReadAddr1,
    input  logic               outValid,
    input  fetchPkg::pc_t      outPc,
    input  fetchPkg::fetchId_t outFetchId,
    input  logic               outPredTaken,
    input  fetchPkg::pc_t      outPredTarget,
    input  logic               outIrq,
    input  fetchPkg::pc_t      pcReadData0,
    input  fetchPkg::pc_t      pcReadData1,
    input  logic               testStart,
    input  logic               testDone,
    input  int                 testNum,
    input  int                 expCount,
    input  fetchPkg::pc_t      expLast,
    input  int                 expIrq,
    output int                 acceptCount,
    output int                 passCount,
    output int                 failCount
);

    localparam int IDX_W = $clog2(`BTB_ENTRIES);

    logic               btbV [`BTB_ENTRIES];
    fetchPkg::pc_t      btbSrc [`BTB_ENTRIES];
    fetchPkg::pc_t      btbDst [`BTB_ENTRIES];
    fetchPkg::pc_t      recPc [2**`FETCH_ID_W];
    logic               recV [2**`FETCH_ID_W];
    fetchPkg::pc_t      expPc;
    fetchPkg::fetchId_t expId;
    fetchPkg::pc_t      lastPc;
    fetchPkg::pc_t      holdPc;
    fetchPkg::fetchId_t holdId;
    logic               holdIrq;
    logic               prevHold;
    logic               irqStop;
    logic               hit;
    int                 quiet;
    int                 irqCount;
    int                 testErr;

    task automatic reportMismatch(input string msg);
        $display("FAIL %0t: test %0d %s", $time, testNum, msg);
        testErr++;
    endtask

    task automatic checkRead(input fetchPkg::fetchId_t addr, input fetchPkg::pc_t data);
        // skip the id whose packet sits unaccepted in the buffer
        if (recV[addr] && !(outValid && !ready && outFetchId == addr) && data != recPc[addr])
            reportMismatch($sformatf("pc file id %0d read %h, expected %h",
                                     addr, data, recPc[addr]));
    endtask

    always @(negedge clk) begin
        if (rst) begin
            expPc = '0;
            expId = '0;
            irqStop = 1'b0;
            prevHold = 1'b0;
            quiet = 0;
            acceptCount = 0;
            passCount = 0;
            failCount = 0;
            irqCount = 0;
            testErr = 0;
            for (int i = 0; i < `BTB_ENTRIES; i++)
                btbV[i] = 1'b0;
            for (int i = 0; i < 2**`FETCH_ID_W; i++)
                recV[i] = 1'b0;
        end else begin
            if (testStart) begin
                acceptCount = 0;
                irqCount = 0;
                testErr = 0;
            end
            if (outValid && prevHold && (outPc != holdPc || outFetchId != holdId
                                         || outIrq != holdIrq))
                reportMismatch("packet changed while decode was not ready");
            if (quiet > 0) begin
                if (interruptPending)
                    quiet = 0;  // pause ends early
                else begin
                    if (outValid)
                        reportMismatch("packet during wfi pause");
                    quiet--;
                end
            end
            if (outValid && ready) begin
                hit = btbV[outPc[2 +: IDX_W]] && btbSrc[outPc[2 +: IDX_W]] == outPc;
                if (irqStop)
                    reportMismatch("packet after the irq packet");
                if (outPc != expPc)
                    reportMismatch($sformatf("pc %h, expected %h", outPc, expPc));
                if (outFetchId != expId)
                    reportMismatch($sformatf("fetch id %0d, expected %0d", outFetchId, expId));
                if (outPredTaken != hit)
                    reportMismatch($sformatf("predTaken %0b at pc %h", outPredTaken, outPc));
                if (hit && outPredTarget != btbDst[outPc[2 +: IDX_W]])
                    reportMismatch($sformatf("predTarget %h at pc %h", outPredTarget, outPc));
                recPc[outFetchId] = outPc;
                recV[outFetchId] = 1'b1;
                acceptCount++;
                lastPc = outPc;
                if (outIrq) begin
                    irqCount++;
                    irqStop = 1'b1;
                end
                expPc = hit ? btbDst[outPc[2 +: IDX_W]] : outPc + 32'd4;
                expId = fetchPkg::fetchId_t'(expId + 1);
            end
            checkRead(pcReadAddr0, pcReadData0);
            checkRead(pcReadAddr1, pcReadData1);
            prevHold = outValid && !ready;
            holdPc = outPc;
            holdId = outFetchId;
            holdIrq = outIrq;
            if (redirValid) begin
                expPc = redirTarget;
                expId = fetchPkg::fetchId_t'(redirFetchId + 1);
                irqStop = 1'b0;
                prevHold = 1'b0;
                for (int i = 0; i < 2**`FETCH_ID_W; i++)
                    recV[i] = 1'b0;
                if (redirWfi)
                    quiet = `WFI_DELAY - 1;
            end
            if (btUpdValid) begin
                btbV[btUpdSrc[2 +: IDX_W]] = 1'b1;
                btbSrc[btUpdSrc[2 +: IDX_W]] = btUpdSrc;
                btbDst[btUpdSrc[2 +: IDX_W]] = btUpdDst;
            end
            if (testDone) begin
                if (acceptCount != expCount)
                    reportMismatch($sformatf("%0d packets, expected %0d", acceptCount, expCount));
                else if (acceptCount > 0 && lastPc != expLast)
                    reportMismatch($sformatf("last pc %h, expected %h", lastPc, expLast));
                if (irqCount != expIrq)
                    reportMismatch($sformatf("%0d irq packets, expected %0d", irqCount, expIrq));
                if (testErr == 0) begin
                    $display("PASS test %0d: %0d packets", testNum, acceptCount);
                    passCount++;
                end else begin
                    $display("test %0d failed with %0d errors", testNum, testErr);
                    failCount++;
                end
            end
        end
    end

endmodule

//--- dv/fetch_patterns.txt
# redir wfi target id | upd src dst | irqAt rnd budget hold | count lastPc irqs  (all hex)
# irqAt counts cycles from the setup cycle, ff means no interrupt; rnd 1 gives random ready
0 0 00000000 0 0 00000000 00000000 ff 0 30 0 14 0000004c 0
1 0 00001000 7 1 00001008 00001040 ff 0 20 0 05 00001044 0
1 0 00002000 c 0 00000000 00000000 ff 1 a0 0 18 0000205c 0
1 0 00003000 2 1 00003010 00003000 ff 1 80 0 0c 00003004 0
1 0 00000200 3 0 00000000 00000000 04 0 20 a 04 0000020c 1
1 1 00000400 9 0 00000000 00000000 ff 0 30 0 03 00000408 0
1 1 00000500 0 0 00000000 00000000 05 0 30 a 01 00000500 1

//--- dv/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- dv/tbFetch.sv
`timescale 1ns/1ps

module tbFetch;

    logic clk, rst;
    logic en, interruptPending, ready;
    logic redirValid, redirWfi, btUpdValid;
    fetchPkg::fetchId_t redirFetchId, comFetchId, pcReadAddr0, pcReadAddr1;
    fetchPkg::pc_t redirTarget, btUpdSrc, btUpdDst;
    logic outValid, outPredTaken, outIrq;
    fetchPkg::pc_t outPc, outPredTarget, pcReadData0, pcReadData1;
    fetchPkg::fetchId_t outFetchId;
    logic testStart, testDone;
    int testNum, expCount, expIrq, acceptCount, passCount, failCount;
    fetchPkg::pc_t expLast;

    int col [16][14];  // one row per test
    int nTests;
    int limit;
    int cycles;
    logic [31:0] rng;

    tbClock clkGen (.clk(clk), .rst(rst));

    fetchUnit u_dut (.*);

    fetchChecker fetchMon (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run passed %0d cycles without finishing", limit);
            $display("Some tests failed");
            $finish;
        end
    end

    // one cycle of stimulus; next com pointer taken from the accept at mid cycle
    task automatic stepCycle(input int t, input int k, input logic rdy);
        fetchPkg::fetchId_t nextCom;
        rng = xorshift(rng);
        nextCom = comFetchId;
        ready = (col[t][8] != 0) ? rng[0] : rdy;
        interruptPending = (k == col[t][7] || k == col[t][7] + 1);
        pcReadAddr0 = fetchPkg::fetchId_t'(rng >> 4);
        pcReadAddr1 = fetchPkg::fetchId_t'(rng >> 9);
        @(negedge clk);
        if (outValid && ready)
            nextCom = fetchPkg::fetchId_t'(outFetchId - 3);
        @(posedge clk);
        #1 comFetchId = nextCom;
    endtask

    initial begin
        int fd;
        int k;
        string line;
        {en, interruptPending, ready, redirValid, redirWfi, btUpdValid} = '0;
        {redirFetchId, comFetchId, pcReadAddr0, pcReadAddr1} = '0;
        {redirTarget, btUpdSrc, btUpdDst} = '0;
        {testStart, testDone, testNum, expCount, expIrq, expLast} = '0;
        cycles = 0;
        limit = 1000;
        rng = 32'd22;
        nTests = 0;
        fd = $fopen("dv/fetch_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file dv/fetch_patterns.txt");
            $display("Some tests failed");
            $finish;
        end else begin
            limit = 200;
            while ($fgets(line, fd) != 0 && nTests < 16) begin
                if (line.len() > 1 && line[0] != "#") begin
                    void'($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[nTests][0], col[nTests][1], col[nTests][2], col[nTests][3],
                        col[nTests][4], col[nTests][5], col[nTests][6], col[nTests][7],
                        col[nTests][8], col[nTests][9], col[nTests][10], col[nTests][11],
                        col[nTests][12], col[nTests][13]));
                    limit += col[nTests][9] + col[nTests][10];
                    nTests++;
                end
            end
            $fclose(fd);
            wait (!rst);
            @(posedge clk);
            #1;
            for (int t = 0; t < nTests; t++) begin
                testNum = t + 1;
                expCount = col[t][11];
                expLast = col[t][12];
                expIrq = col[t][13];
                testStart = 1'b1;
                // setup cycle, redirect and btb update, decode not ready
                redirValid = col[t][0][0];
                redirWfi = col[t][1][0];
                redirTarget = col[t][2];
                redirFetchId = fetchPkg::fetchId_t'(col[t][3]);
                btUpdValid = col[t][4][0];
                btUpdSrc = col[t][5];
                btUpdDst = col[t][6];
                if (redirValid)
                    comFetchId = fetchPkg::fetchId_t'(col[t][3] - 2);
                @(posedge clk);
                #1 {testStart, redirValid, redirWfi, btUpdValid} = '0;
                en = 1'b1;
                k = 1;
                // budget bounds the wait so a short stream shows up as a count error
                while (acceptCount < expCount && k <= col[t][9]) begin
                    stepCycle(t, k, 1'b1);
                    k++;
                end
                for (int h = 0; h < col[t][10]; h++) begin
                    stepCycle(t, k, 1'b1);
                    k++;
                end
                {en, ready, interruptPending} = '0;
                testDone = 1'b1;
                @(posedge clk);
                #1 testDone = 1'b0;
            end
            $display("%0d tests run, %0d passed, %0d failed", nTests, passCount, failCount);
            if (failCount == 0 && passCount == nTests)
                $display("All tests passed");
            else
                $display("Some tests failed");
            $finish;
        end
    end

endmodule

//--- include/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// fetch id ring, 16 ids in flight at most
`define FETCH_ID_W 4

// direct-mapped btb, power of two
`define BTB_ENTRIES 16

// longest wfi pause in cycles
`define WFI_DELAY 16

`endif

//--- project.f
+incdir+include
src/fetchPkg.sv
src/branchPredictor.sv
src/fetchTable.sv
src/pcFile.sv
src/fetchUnit.sv
dv/tbClock.sv
dv/fetchChecker.sv
dv/tbFetch.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch testbench with verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -f project.f --top-module tbFetch -o simv > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1 || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }

//--- src/branchPredictor.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module branchPredictor (
    input  logic          clk,
    input  logic          rst,
    input  logic          fetchEn,
    input  logic          redirValid,
    input  fetchPkg::pc_t redirTarget,
    input  logic          btUpdValid,
    input  fetchPkg::pc_t btUpdSrc,
    input  fetchPkg::pc_t btUpdDst,
    output fetchPkg::pc_t pc,
    output logic          predTaken,
    output fetchPkg::pc_t predTarget
);

    localparam int IDX_W = $bits(fetchPkg::btbIdx_t);
    localparam int TAG_W = $bits(fetchPkg::btbTag_t);

    logic [`BTB_ENTRIES-1:0] btbValid;
    fetchPkg::btbTag_t       btbTag [`BTB_ENTRIES];
    fetchPkg::pc_t           btbTarget [`BTB_ENTRIES];

    fetchPkg::btbIdx_t lookIdx;
    fetchPkg::btbTag_t lookTag;
    fetchPkg::btbIdx_t updIdx;
    fetchPkg::btbTag_t updTag;
    fetchPkg::pc_t     nextPc;

    assign lookIdx = pc[2 +: IDX_W];
    assign lookTag = pc[31 -: TAG_W];
    assign updIdx  = btUpdSrc[2 +: IDX_W];
    assign updTag  = btUpdSrc[31 -: TAG_W];

    // combinational lookup of the current fetch pc
    assign predTaken  = btbValid[lookIdx] && (btbTag[lookIdx] == lookTag);
    assign predTarget = btbTarget[lookIdx];

    always_comb begin
        nextPc = pc;  // hold while not fetching
        if (redirValid)
            nextPc = redirTarget;
        else if (fetchEn)
            nextPc = predTaken ? predTarget : pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (rst)
            pc <= '0;
        else
            pc <= nextPc;
    end

    always_ff @(posedge clk) begin
        if (rst)
            btbValid <= '0;
        else if (btUpdValid)
            btbValid[updIdx] <= 1'b1;
    end

    // same-cycle lookup still reads the old entry
    always_ff @(posedge clk) begin
        if (btUpdValid) begin
            btbTag[updIdx]    <= updTag;
            btbTarget[updIdx] <= btUpdDst;
        end
    end

endmodule

//--- src/fetchPkg.sv
`include "fetch_settings.svh"

package fetchPkg;

    // byte address, bits 1:0 stay zero
    typedef logic [31:0] pc_t;

    typedef logic [`FETCH_ID_W-1:0] fetchId_t;

    // btb index sits right above the two zero bits of the pc
    typedef logic [$clog2(`BTB_ENTRIES)-1:0] btbIdx_t;

    // everything above the index
    typedef logic [29-$clog2(`BTB_ENTRIES):0] btbTag_t;

    typedef enum logic [1:0] {
        RUN,
        WAIT_INT,  // paused by wfi
        INT_SENT   // irq packet out, wait for redirect
    } fetchState_t;

endpackage

//--- src/fetchTable.sv
`timescale 1ns/1ps

module fetchTable (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetchEn,
    input  logic               fetchIrq,
    input  fetchPkg::pc_t      pc,
    input  logic               predTaken,
    input  fetchPkg::pc_t      predTarget,
    input  logic               redirValid,
    input  fetchPkg::fetchId_t redirFetchId,
    input  fetchPkg::fetchId_t comFetchId,
    input  logic               ready,
    output logic               stall,
    output logic               pcfWe,
    output fetchPkg::fetchId_t pcfAddr,
    output fetchPkg::pc_t      pcfData,
    output logic               outValid,
    output fetchPkg::pc_t      outPc,
    output fetchPkg::fetchId_t outFetchId,
    output logic               outPredTaken,
    output fetchPkg::pc_t      outPredTarget,
    output logic               outIrq
);

    fetchPkg::fetchId_t nextId;
    logic               doFetch;
    logic               windowFull;
    logic               bufBlocked;

    assign doFetch = fetchEn && !redirValid;  // redirect wins

    // keep one id free so the ring never wraps onto the commit pointer
    assign windowFull = (fetchPkg::fetchId_t'(nextId + 1'b1) == comFetchId);
    assign bufBlocked = outValid && !ready;
    assign stall      = bufBlocked || windowFull;

    assign pcfWe   = doFetch;
    assign pcfAddr = nextId;
    assign pcfData = pc;

    always_ff @(posedge clk) begin
        if (rst)
            nextId <= '0;
        else if (redirValid)
            nextId <= redirFetchId + 1'b1;
        else if (doFetch)
            nextId <= nextId + 1'b1;
    end

    // one-entry output buffer
    always_ff @(posedge clk) begin
        if (rst)
            outValid <= 1'b0;
        else if (redirValid)
            outValid <= 1'b0;
        else if (doFetch)
            outValid <= 1'b1;
        else if (ready)
            outValid <= 1'b0;  // packet taken by decode
    end

    always_ff @(posedge clk) begin
        if (doFetch) begin
            outPc         <= pc;
            outFetchId    <= nextId;
            outPredTaken  <= predTaken;
            outPredTarget <= predTarget;
            outIrq        <= fetchIrq;
        end
    end

endmodule

//--- src/fetchUnit.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetchUnit (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  logic               interruptPending,
    input  logic               redirValid,
    input  fetchPkg::fetchId_t redirFetchId,
    input  fetchPkg::pc_t      redirTarget,
    input  logic               redirWfi,
    input  logic               btUpdValid,
    input  fetchPkg::pc_t      btUpdSrc,
    input  fetchPkg::pc_t      btUpdDst,
    input  fetchPkg::fetchId_t comFetchId,
    input  logic               ready,
    input  fetchPkg::fetchId_t pcReadAddr0,
    input  fetchPkg::fetchId_t pcReadAddr1,
    output logic               outValid,
    output fetchPkg::pc_t      outPc,
    output fetchPkg::fetchId_t outFetchId,
    output logic               outPredTaken,
    output fetchPkg::pc_t      outPredTarget,
    output logic               outIrq,
    output fetchPkg::pc_t      pcReadData0,
    output fetchPkg::pc_t      pcReadData1
);

    localparam int CNT_W = $clog2(`WFI_DELAY);

    fetchPkg::fetchState_t state;
    logic [CNT_W-1:0]      wfiCount;

    logic               fetchEn;
    logic               fetchIrq;
    logic               stall;
    fetchPkg::pc_t      pc;
    logic               predTaken;
    fetchPkg::pc_t      predTarget;
    logic               pcfWe;
    fetchPkg::fetchId_t pcfAddr;
    fetchPkg::pc_t      pcfData;

    assign fetchEn  = en && (state == fetchPkg::RUN) && !stall;
    assign fetchIrq = interruptPending;  // this fetch becomes the fake irq packet

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fetchPkg::RUN;
            wfiCount <= '0;
        end else if (redirValid) begin
            // a redirect also clears a pending irq stop
            if (redirWfi) begin
                state    <= fetchPkg::WAIT_INT;
                wfiCount <= CNT_W'(`WFI_DELAY - 1);
            end else begin
                state <= fetchPkg::RUN;
            end
        end else begin
            case (state)
                fetchPkg::WAIT_INT: begin
                    if (interruptPending || wfiCount == '0)
                        state <= fetchPkg::RUN;
                    else
                        wfiCount <= wfiCount - 1'b1;
                end
                fetchPkg::RUN: begin
                    if (fetchEn && interruptPending)
                        state <= fetchPkg::INT_SENT;
                end
                default: ;  // INT_SENT holds until redirect
            endcase
        end
    end

    branchPredictor branchPred (
        .clk        (clk),
        .rst        (rst),
        .fetchEn    (fetchEn),
        .redirValid (redirValid),
        .redirTarget(redirTarget),
        .btUpdValid (btUpdValid),
        .btUpdSrc   (btUpdSrc),
        .btUpdDst   (btUpdDst),
        .pc         (pc),
        .predTaken  (predTaken),
        .predTarget (predTarget)
    );

    fetchTable fetchTab (
        .clk          (clk),
        .rst          (rst),
        .fetchEn      (fetchEn),
        .fetchIrq     (fetchIrq),
        .pc           (pc),
        .predTaken    (predTaken),
        .predTarget   (predTarget),
        .redirValid   (redirValid),
        .redirFetchId (redirFetchId),
        .comFetchId   (comFetchId),
        .ready        (ready),
        .stall        (stall),
        .pcfWe        (pcfWe),
        .pcfAddr      (pcfAddr),
        .pcfData      (pcfData),
        .outValid     (outValid),
        .outPc        (outPc),
        .outFetchId   (outFetchId),
        .outPredTaken (outPredTaken),
        .outPredTarget(outPredTarget),
        .outIrq       (outIrq)
    );

    pcFile pcRegs (
        .clk   (clk),
        .we    (pcfWe),
        .waddr (pcfAddr),
        .wdata (pcfData),
        .raddr0(pcReadAddr0),
        .raddr1(pcReadAddr1),
        .rdata0(pcReadData0),
        .rdata1(pcReadData1)
    );

endmodule

//--- src/pcFile.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module pcFile (
    input  logic               clk,
    input  logic               we,
    input  fetchPkg::fetchId_t waddr,
    input  fetchPkg::pc_t      wdata,
    input  fetchPkg::fetchId_t raddr0,
    input  fetchPkg::fetchId_t raddr1,
    output fetchPkg::pc_t      rdata0,
    output fetchPkg::pc_t      rdata1
);

    // one pc per fetch id
    fetchPkg::pc_t mem [2**`FETCH_ID_W];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    assign rdata0 = mem[raddr0];  // async reads
    assign rdata1 = mem[raddr1];

endmodule
